//--- hdl/zx_mem_params.svh
`ifndef ZX_MEM_PARAMS_SVH
`define ZX_MEM_PARAMS_SVH

// --------------------------------------------------
// internal register file addresses
// --------------------------------------------------
`define ZXM_MASTERCONF          8'h00      // master configuration
`define ZXM_MASTERMAPPER        8'h01      // master mapper, boot only

// --------------------------------------------------
// i/o port decode
// --------------------------------------------------
// divmmc control sits on the low byte only, high byte ignored
`define ZXM_PORT_DIVMMC         8'hE3

// --------------------------------------------------
// physical sram map, 2MB
// --------------------------------------------------
// 16K ROM banks live in sram pages 8..11
`define ZXM_ROM_REGION          5'b00010
// divmmc eeprom image, one 8K page
`define ZXM_DIVMMC_ROM_PAGE     8'b00011000
// divmmc ram, sixteen 8K pages from 0x040000
`define ZXM_DIVMMC_RAM_REGION   4'b0010
// mapram mode puts this ram page where the eeprom was
`define ZXM_DIVMMC_MAPRAM_PAGE  4'd3

`endif

//--- hdl/zx_mem_pkg.sv
package zx_mem_pkg;

   // --------------------------------------------------
   // cpu side
   // --------------------------------------------------
   typedef logic [15:0] cpu_addr_t;   // z80 address bus
   typedef logic [7:0]  byte_t;       // data byte, cpu bus and registers

   // --------------------------------------------------
   // memory side
   // --------------------------------------------------
   // 2MB of sram, byte addressed
   typedef logic [20:0] sram_addr_t;

   // one of the eight 16K pages of the 128K machine
   typedef logic [2:0]  ram_page_t;

   // master mapper picks any 16K page of the sram for $C000
   // in boot mode, 7 bits cover all 128 pages
   typedef logic [6:0]  mapper_t;

endpackage

//--- hdl/master_conf.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module master_conf (
   input  logic               clk,
   input  logic               mrst_n,
   input  zx_mem_pkg::byte_t  addr,                     // internal register address
   input  zx_mem_pkg::byte_t  din,
   input  logic               iow,                      // internal register write strobe
   output logic               boot_mode,
   output logic               divmmc_en,
   output logic               nmi_dis,
   output logic               issue2_keyboard_enabled,
   output logic               disable_contention,
   output logic [1:0]         timing_mode,
   output logic               in_boot_mode,
   output zx_mem_pkg::mapper_t mastermapper,
   output zx_mem_pkg::byte_t  conf_q,                   // read-back of masterconf
   output zx_mem_pkg::byte_t  mapper_q                  // read-back of mastermapper
);

   import zx_mem_pkg::*;

   // conf_r layout
   //   7 freeze, 6 timing[1], 5 no contention, 4 timing[0]
   //   3 issue2, 2 nmi disable, 1 divmmc enable, 0 boot
   byte_t   conf_r;
   mapper_t mapper_r;

   logic conf_wr;
   logic mapper_wr;

   assign conf_wr   = iow && (addr == `ZXM_MASTERCONF);
   assign mapper_wr = iow && (addr == `ZXM_MASTERMAPPER) && boot_mode;   // boot only

   always_ff @(posedge clk) begin
      if (!mrst_n) begin
         conf_r <= 8'h01;                       // start in boot mode, unfrozen
      end else if (conf_wr) begin
         conf_r[6:3] <= din[6:3];               // options always writable
         if (!conf_r[7]) begin
            conf_r[7]   <= din[7];              // freeze is one way
            conf_r[2:0] <= din[2:0];
         end
      end
   end

   always_ff @(posedge clk) begin
      if (!mrst_n)
         mapper_r <= '0;
      else if (mapper_wr)
         mapper_r <= din[6:0];
   end

   assign boot_mode               = conf_r[0];
   assign divmmc_en               = conf_r[1];
   assign nmi_dis                 = conf_r[2];
   assign issue2_keyboard_enabled = conf_r[3];
   assign disable_contention      = conf_r[5];
   assign timing_mode             = {conf_r[6], conf_r[4]};
   assign in_boot_mode            = ~conf_r[7];
   assign mastermapper            = mapper_r;

   assign conf_q   = conf_r;
   assign mapper_q = {1'b0, mapper_r};

   // after freeze nothing but mrst_n may bring the boot rom back
   a_frozen_no_boot: assert property (@(posedge clk) disable iff (!mrst_n)
      !in_boot_mode |=> !$rose(boot_mode))
      else $error("boot_mode rose while frozen");

endmodule

//--- hdl/divmmc_automap.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module divmmc_automap (
   input  logic                 clk,
   input  logic                 mrst_n,
   input  logic                 rst_n,          // cpu reset
   input  zx_mem_pkg::cpu_addr_t a,
   input  zx_mem_pkg::byte_t    din,
   input  logic                 iorq_n,
   input  logic                 wr_n,
   input  logic                 mreq_n,
   input  logic                 rd_n,
   input  logic                 m1_n,
   input  logic                 divmmc_en,
   input  logic                 nmi_dis,
   output logic                 rom_active,
   output logic                 mapram,
   output logic                 conmem,
   output logic [3:0]           divmmc_page,
   output logic                 enable_nmi_n
);

   import zx_mem_pkg::*;

   // --------------------------------------------------
   // control register, port E3
   // --------------------------------------------------
   byte_t ctrl_r;                                // 7 conmem, 6 mapram, 3..0 ram page

   always_ff @(posedge clk) begin
      if (!mrst_n)
         ctrl_r <= 8'h00;
      else if (!rst_n)
         ctrl_r <= {1'b0, ctrl_r[6], 6'b000000};  // mapram survives a cpu reset
      else if (!iorq_n && !wr_n && a[7:0] == `ZXM_PORT_DIVMMC)
         ctrl_r <= {din[7], din[6] | ctrl_r[6], din[5:0]};   // mapram is sticky
   end

   assign conmem      = ctrl_r[7];
   assign mapram      = ctrl_r[6];
   assign divmmc_page = ctrl_r[3:0];

   // --------------------------------------------------
   // automapper
   // --------------------------------------------------
   logic m1_fetch;
   logic deferred_hit;
   logic exit_hit;
   logic imm_entry;
   logic pending;                                // state to take once m1 ends
   logic paged;

   assign m1_fetch     = !mreq_n && !rd_n && !m1_n;
   assign deferred_hit = (a == 16'h0000) || (a == 16'h0008) || (a == 16'h0038) ||
                         (a == 16'h0066 && !nmi_dis) ||       // nmi entry point
                         (a == 16'h04C6) || (a == 16'h0562);  // tape load/save hooks
   assign imm_entry    = m1_fetch && a[15:8] == 8'h3D;        // trdos entry, pages at once
   assign exit_hit     = a[15:3] == 13'h03FF;                 // 1FF8..1FFF

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         pending <= 1'b0;
         paged   <= 1'b0;
      end else begin
         if (m1_fetch && deferred_hit) begin
            pending <= 1'b1;
         end else if (imm_entry) begin
            pending <= 1'b1;
            paged   <= 1'b1;
         end else if (m1_fetch && exit_hit) begin
            pending <= 1'b0;
         end
         if (m1_n)
            paged <= pending;                     // switch only between fetches
      end
   end

   assign rom_active   = divmmc_en && (paged || conmem);
   assign enable_nmi_n = divmmc_en & paged & ~nmi_dis;

   // paging never moves in the middle of an opcode fetch, except on 3Dxx
   a_paged_timing: assert property (@(posedge clk) disable iff (!mrst_n || !rst_n)
      $changed(paged) |-> $past(m1_n) || $past(imm_entry) || $past(!mrst_n || !rst_n))
      else $error("divmmc paged changed inside an m1 cycle");

endmodule

//--- hdl/bank_ports.sv
`timescale 1ns/1ps

module bank_ports (
   input  logic                  clk,
   input  logic                  mrst_n,
   input  logic                  rst_n,
   input  zx_mem_pkg::cpu_addr_t a,
   input  zx_mem_pkg::byte_t     din,
   input  logic                  iorq_n,
   input  logic                  wr_n,
   output zx_mem_pkg::ram_page_t ram_bank,      // page at $C000
   output logic                  vram_page,     // shadow screen select
   output logic [1:0]            rom_bank,
   output logic                  allram,        // +3 special paging
   output logic [1:0]            arrangement,
   output logic                  in48kmode
);

   import zx_mem_pkg::*;

   byte_t bank128;                               // port 7FFD
   byte_t bankplus3;                             // port 1FFD
   logic  io_wr;
   logic  sel_7ffd;
   logic  sel_1ffd;
   logic  locked;

   assign io_wr    = !iorq_n && !wr_n;
   assign sel_7ffd = !a[1] && a[15:14] == 2'b01;     // +2A partial decode
   assign sel_1ffd = !a[1] && a[15:12] == 4'b0001;
   assign locked   = bank128[5];

   always_ff @(posedge clk) begin
      if (!mrst_n || !rst_n) begin
         bank128   <= 8'h00;
         bankplus3 <= 8'h00;
      end else if (io_wr && !locked) begin     // lock freezes both ports
         if (sel_1ffd)
            bankplus3 <= din;
         else if (sel_7ffd)
            bank128 <= din;
      end
   end

   assign ram_bank    = bank128[2:0];
   assign vram_page   = bank128[3];
   assign rom_bank    = {bankplus3[2], bank128[4]};   // rom 3 is the 48K basic
   assign allram      = bankplus3[0];
   assign arrangement = bankplus3[2:1];
   assign in48kmode   = locked;

   // once locked only a reset may touch the paging
   a_lock_holds: assert property (@(posedge clk) disable iff (!mrst_n || !rst_n)
      locked |=> $stable(bank128) && $stable(bankplus3))
      else $error("paging register changed while locked");

endmodule

//--- hdl/addr_translate.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module addr_translate (
   input  zx_mem_pkg::cpu_addr_t  a,
   input  logic                   mreq_n,
   input  logic                   rd_n,
   input  logic                   wr_n,
   input  logic                   boot_mode,
   input  zx_mem_pkg::mapper_t    mastermapper,
   input  logic                   rom_active,
   input  logic                   mapram,
   input  logic                   conmem,
   input  logic [3:0]             divmmc_page,
   input  zx_mem_pkg::ram_page_t  ram_bank,
   input  logic [1:0]             rom_bank,
   input  logic                   allram,
   input  logic [1:0]             arrangement,
   output zx_mem_pkg::sram_addr_t mem_addr,
   output logic                   mem_oe_n,
   output logic                   mem_we_n,
   output logic                   bootrom_sel,
   output logic                   access_to_screen
);

   import zx_mem_pkg::*;

   ram_page_t page;                              // 16K ram page for plain mappings
   logic      ram_map;                           // use page, else mem_addr set directly
   logic      mapram_rom;

   assign mapram_rom = mapram && !conmem;        // conmem shows the eeprom instead

   always_comb begin
      mem_oe_n    = mreq_n | rd_n;
      mem_we_n    = mreq_n | wr_n;
      bootrom_sel = 1'b0;
      page        = 3'd0;
      ram_map     = 1'b1;
      mem_addr    = '0;
      // --------------------------------------------------
      case (a[15:14])
         2'b00: begin
            if (boot_mode) begin                 // internal boot rom, sram idle
               bootrom_sel = !mreq_n && !rd_n;
               mem_oe_n    = 1'b1;
               mem_we_n    = 1'b1;
               ram_map     = 1'b0;
            end else if (rom_active) begin       // divmmc wins over everything
               ram_map = 1'b0;
               if (!a[13]) begin
                  if (mapram_rom)
                     mem_addr = {`ZXM_DIVMMC_RAM_REGION, `ZXM_DIVMMC_MAPRAM_PAGE, a[12:0]};
                  else
                     mem_addr = {`ZXM_DIVMMC_ROM_PAGE, a[12:0]};
                  mem_we_n = 1'b1;               // low 8K is never written
               end else begin
                  mem_addr = {`ZXM_DIVMMC_RAM_REGION, divmmc_page, a[12:0]};
                  if (mapram && divmmc_page == `ZXM_DIVMMC_MAPRAM_PAGE)
                     mem_we_n = 1'b1;            // page 3 acts as rom
               end
            end else if (!allram) begin
               ram_map  = 1'b0;
               mem_addr = {`ZXM_ROM_REGION, rom_bank, a[13:0]};
               mem_we_n = 1'b1;
            end else begin
               page = (arrangement == 2'b00) ? 3'd0 : 3'd4;
            end
         end
         // --------------------------------------------------
         2'b01: begin
            if (boot_mode || !allram)
               page = 3'd5;
            else if (arrangement == 2'b00)
               page = 3'd1;
            else if (arrangement == 2'b11)
               page = 3'd7;
            else
               page = 3'd5;
         end
         2'b10: begin
            if (boot_mode || !allram || arrangement == 2'b00)
               page = 3'd2;
            else
               page = 3'd6;
         end
         // --------------------------------------------------
         default: begin
            if (boot_mode) begin                 // any 16K of sram
               ram_map  = 1'b0;
               mem_addr = {mastermapper, a[13:0]};
            end else if (!allram) begin
               page = ram_bank;
            end else begin
               page = (arrangement == 2'b01) ? 3'd7 : 3'd3;
            end
         end
      endcase
      if (ram_map)
         mem_addr = {4'b0000, page, a[13:0]};
   end

   // screen pages 5 and 7 are contended, odd banks in 128K paging
   assign access_to_screen = !boot_mode && !allram &&
                             (a[15:14] == 2'b01 || (a[15:14] == 2'b11 && ram_bank[0]));

endmodule

//--- hdl/zx_memory.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module zx_memory (
   input  logic                   clk,
   input  logic                   mrst_n,
   input  logic                   rst_n,
   input  zx_mem_pkg::cpu_addr_t  a,
   input  zx_mem_pkg::byte_t      din,
   input  logic                   mreq_n,
   input  logic                   iorq_n,
   input  logic                   rd_n,
   input  logic                   wr_n,
   input  logic                   m1_n,
   input  zx_mem_pkg::byte_t      addr,          // internal register address
   input  logic                   ior,
   input  logic                   iow,
   input  zx_mem_pkg::byte_t      ram_dout,      // sram read data
   input  zx_mem_pkg::byte_t      bootrom_dout,
   output zx_mem_pkg::byte_t      dout,
   output logic                   oe,
   output zx_mem_pkg::sram_addr_t mem_addr,
   output logic                   mem_oe_n,
   output logic                   mem_we_n,
   output logic                   enable_nmi_n,
   output logic                   in_boot_mode,
   output logic                   in48kmode,
   output logic                   access_to_screen,
   output logic [1:0]             timing_mode,
   output logic                   issue2_keyboard_enabled,
   output logic                   disable_contention
);

   import zx_mem_pkg::*;

   logic      boot_mode, divmmc_en, nmi_dis;
   mapper_t   mastermapper;
   byte_t     conf_q, mapper_q;
   logic      rom_active, mapram, conmem;
   logic [3:0] divmmc_page;
   ram_page_t ram_bank;
   logic [1:0] rom_bank, arrangement;
   logic      allram, bootrom_sel;

   master_conf i_master_conf (
      .clk(clk), .mrst_n(mrst_n), .addr(addr), .din(din), .iow(iow),
      .boot_mode(boot_mode), .divmmc_en(divmmc_en), .nmi_dis(nmi_dis),
      .issue2_keyboard_enabled(issue2_keyboard_enabled),
      .disable_contention(disable_contention), .timing_mode(timing_mode),
      .in_boot_mode(in_boot_mode), .mastermapper(mastermapper),
      .conf_q(conf_q), .mapper_q(mapper_q)
   );

   divmmc_automap i_divmmc_automap (
      .clk(clk), .mrst_n(mrst_n), .rst_n(rst_n), .a(a), .din(din),
      .iorq_n(iorq_n), .wr_n(wr_n), .mreq_n(mreq_n), .rd_n(rd_n), .m1_n(m1_n),
      .divmmc_en(divmmc_en), .nmi_dis(nmi_dis), .rom_active(rom_active),
      .mapram(mapram), .conmem(conmem), .divmmc_page(divmmc_page),
      .enable_nmi_n(enable_nmi_n)
   );

   bank_ports i_bank_ports (
      .clk(clk), .mrst_n(mrst_n), .rst_n(rst_n), .a(a), .din(din),
      .iorq_n(iorq_n), .wr_n(wr_n), .ram_bank(ram_bank),
      .vram_page(),                              // no video mirror in this build
      .rom_bank(rom_bank), .allram(allram), .arrangement(arrangement),
      .in48kmode(in48kmode)
   );

   addr_translate i_addr_translate (
      .a(a), .mreq_n(mreq_n), .rd_n(rd_n), .wr_n(wr_n), .boot_mode(boot_mode),
      .mastermapper(mastermapper), .rom_active(rom_active), .mapram(mapram),
      .conmem(conmem), .divmmc_page(divmmc_page), .ram_bank(ram_bank),
      .rom_bank(rom_bank), .allram(allram), .arrangement(arrangement),
      .mem_addr(mem_addr), .mem_oe_n(mem_oe_n), .mem_we_n(mem_we_n),
      .bootrom_sel(bootrom_sel), .access_to_screen(access_to_screen)
   );

   // --------------------------------------------------
   // cpu read data, first match wins
   // --------------------------------------------------
   always_comb begin
      oe   = 1'b1;
      dout = 8'hFF;
      if (bootrom_sel)
         dout = bootrom_dout;
      else if (!mem_oe_n)
         dout = ram_dout;
      else if (ior && addr == `ZXM_MASTERCONF)
         dout = conf_q;
      else if (ior && addr == `ZXM_MASTERMAPPER)
         dout = mapper_q;
      else
         oe = 1'b0;                              // nobody drives the bus
   end

   // rom images and the mapram page never see a write strobe
   a_rom_never_written: assert property (@(posedge clk) disable iff (!mrst_n)
      !mem_we_n |-> mem_addr[20:16] != `ZXM_ROM_REGION &&
                    mem_addr[20:13] != `ZXM_DIVMMC_ROM_PAGE &&
                    !(mapram && mem_addr[20:13] ==
                      {`ZXM_DIVMMC_RAM_REGION, `ZXM_DIVMMC_MAPRAM_PAGE}))
      else $error("write strobe into a rom region");

endmodule

//--- bench/tb_zx_memory.sv
`timescale 1ns/1ps
`include "zx_mem_params.svh"

module tb_zx_memory;

   import zx_mem_pkg::*;

   // --------------------------------------------------
   // dut signals
   // --------------------------------------------------
   logic       clk, mrst_n, rst_n;
   cpu_addr_t  a;
   byte_t      din, addr, ram_dout, bootrom_dout, dout;
   logic       mreq_n, iorq_n, rd_n, wr_n, m1_n, ior, iow;
   logic       oe, mem_oe_n, mem_we_n, enable_nmi_n, in_boot_mode, in48kmode;
   logic       access_to_screen, issue2_keyboard_enabled, disable_contention;
   logic [1:0] timing_mode;
   sram_addr_t mem_addr;

   // register model, same edge as the dut
   byte_t      m_conf, m_7ffd, m_1ffd, m_ctrl;
   mapper_t    m_mapper;
   logic       m_pend, m_paged;

   logic        chk_en;
   logic [22:0] exp_r;                          // {boot rom, write protect, address}
   logic        exp_we, exp_oen, exp_oe, exp_scr, exp_nmi, rd_mem;
   byte_t       exp_dout;
   int          cmp_errors, seq_errors, checks, tests, err_mark, i, j;
   integer      seed;
   logic [31:0] rnd;

   zx_memory i_dut (.*);

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // --------------------------------------------------
   // expected physical address from the memory map
   // --------------------------------------------------
   function automatic logic [22:0] ref_addr(input cpu_addr_t ca, input byte_t conf,
      input mapper_t mapper, input byte_t p7ffd, input byte_t p1ffd, input byte_t ctrl,
      input logic paged);
      logic [1:0]  q;
      logic [11:0] tbl;                         // all-ram pages, quarter 0 first
      logic        wp, no_sram;
      sram_addr_t  pa;
      q       = ca[15:14];
      wp      = 1'b0;
      no_sram = 1'b0;
      pa      = '0;
      case (p1ffd[2:1])
         2'b00:   tbl = {3'd0, 3'd1, 3'd2, 3'd3};
         2'b01:   tbl = {3'd4, 3'd5, 3'd6, 3'd7};
         2'b10:   tbl = {3'd4, 3'd5, 3'd6, 3'd3};
         default: tbl = {3'd4, 3'd7, 3'd6, 3'd3};
      endcase
      if (conf[0]) begin                        // boot mode
         case (q)
            2'b00:   no_sram = 1'b1;
            2'b01:   pa = {4'b0000, 3'd5, ca[13:0]};
            2'b10:   pa = {4'b0000, 3'd2, ca[13:0]};
            default: pa = {mapper, ca[13:0]};
         endcase
      end else if (q == 2'b00 && conf[1] && (paged || ctrl[7])) begin
         if (!ca[13]) begin
            wp = 1'b1;                          // eeprom half, read only
            if (ctrl[6] && !ctrl[7])            // conmem brings the eeprom back
               pa = {`ZXM_DIVMMC_RAM_REGION, `ZXM_DIVMMC_MAPRAM_PAGE, ca[12:0]};
            else
               pa = {`ZXM_DIVMMC_ROM_PAGE, ca[12:0]};
         end else begin
            pa = {`ZXM_DIVMMC_RAM_REGION, ctrl[3:0], ca[12:0]};
            wp = ctrl[6] && ctrl[3:0] == `ZXM_DIVMMC_MAPRAM_PAGE;
         end
      end else if (p1ffd[0]) begin
         case (q)
            2'b00:   pa = {4'b0000, tbl[11:9], ca[13:0]};
            2'b01:   pa = {4'b0000, tbl[8:6], ca[13:0]};
            2'b10:   pa = {4'b0000, tbl[5:3], ca[13:0]};
            default: pa = {4'b0000, tbl[2:0], ca[13:0]};
         endcase
      end else begin
         case (q)
            2'b00: begin
               pa = {`ZXM_ROM_REGION, p1ffd[2], p7ffd[4], ca[13:0]};
               wp = 1'b1;
            end
            2'b01:   pa = {4'b0000, 3'd5, ca[13:0]};
            2'b10:   pa = {4'b0000, 3'd2, ca[13:0]};
            default: pa = {4'b0000, p7ffd[2:0], ca[13:0]};
         endcase
      end
      return {no_sram, wp, pa};
   endfunction

   // --------------------------------------------------
   // register model
   // --------------------------------------------------
   always @(posedge clk) begin
      if (!mrst_n) begin
         m_conf   <= 8'h01;                     // boot mode, not frozen
         m_mapper <= '0;
         m_7ffd   <= 8'h00;
         m_1ffd   <= 8'h00;
         m_ctrl   <= 8'h00;
         m_pend   <= 1'b0;
         m_paged  <= 1'b0;
      end else begin
         if (iow && addr == `ZXM_MASTERCONF) begin
            m_conf[6:3] <= din[6:3];
            if (!m_conf[7])
               {m_conf[7], m_conf[2:0]} <= {din[7], din[2:0]};
         end
         if (iow && addr == `ZXM_MASTERMAPPER && m_conf[0])
            m_mapper <= din[6:0];
         if (!rst_n) begin
            m_7ffd  <= 8'h00;
            m_1ffd  <= 8'h00;
            m_ctrl  <= {1'b0, m_ctrl[6], 6'b000000};   // mapram kept
            m_pend  <= 1'b0;
            m_paged <= 1'b0;
         end else begin
            if (!iorq_n && !wr_n && a[7:0] == `ZXM_PORT_DIVMMC)
               m_ctrl <= {din[7], din[6] | m_ctrl[6], din[5:0]};
            if (!iorq_n && !wr_n && !m_7ffd[5] && !a[1] && a[15:12] == 4'b0001)
               m_1ffd <= din;
            if (!iorq_n && !wr_n && !m_7ffd[5] && !a[1] && a[15:14] == 2'b01)
               m_7ffd <= din;
            if (!mreq_n && !rd_n && !m1_n) begin
               if (a == 16'h0000 || a == 16'h0008 || a == 16'h0038 || a == 16'h04C6 ||
                   a == 16'h0562 || (a == 16'h0066 && !m_conf[2]))
                  m_pend <= 1'b1;
               else if (a[15:8] == 8'h3D) begin
                  m_pend  <= 1'b1;
                  m_paged <= 1'b1;              // trdos hook pages right away
               end else if (a >= 16'h1FF8 && a <= 16'h1FFF)
                  m_pend <= 1'b0;
            end
            if (m1_n)
               m_paged <= m_pend;
         end
      end
   end

   // --------------------------------------------------
   // compare, outputs are stable half a cycle after the drive
   // --------------------------------------------------
   always @(posedge clk) begin
      if (chk_en) begin
         exp_r   = ref_addr(a, m_conf, m_mapper, m_7ffd, m_1ffd, m_ctrl, m_paged);
         rd_mem  = !mreq_n && !rd_n;
         exp_we  = mreq_n || wr_n || exp_r[21] || exp_r[22];
         exp_oen = !rd_mem || exp_r[22];
         exp_oe  = 1'b1;
         if (rd_mem && exp_r[22])
            exp_dout = bootrom_dout;
         else if (rd_mem)
            exp_dout = ram_dout;
         else if (ior && addr == `ZXM_MASTERCONF)
            exp_dout = m_conf;
         else if (ior && addr == `ZXM_MASTERMAPPER)
            exp_dout = {1'b0, m_mapper};
         else begin
            exp_dout = 8'hFF;
            exp_oe   = 1'b0;
         end
         exp_scr = !m_conf[0] && !m_1ffd[0] &&
                   (a[15:14] == 2'b01 || (a[15:14] == 2'b11 && m_7ffd[0]));
         exp_nmi = m_conf[1] && m_paged && !m_conf[2];
         checks += 10;
         if (!exp_r[22] && mem_addr !== exp_r[20:0]) begin
            $display("ERR %0t mem_addr exp=%h got=%h", $time, exp_r[20:0], mem_addr);
            cmp_errors++;
         end
         if (mem_we_n !== exp_we) begin
            $display("ERR %0t mem_we_n exp=%b got=%b", $time, exp_we, mem_we_n);
            cmp_errors++;
         end
         if (mem_oe_n !== exp_oen) begin
            $display("ERR %0t mem_oe_n exp=%b got=%b", $time, exp_oen, mem_oe_n);
            cmp_errors++;
         end
         if (dout !== exp_dout) begin
            $display("ERR %0t dout exp=%h got=%h", $time, exp_dout, dout);
            cmp_errors++;
         end
         if (oe !== exp_oe) begin
            $display("ERR %0t oe exp=%b got=%b", $time, exp_oe, oe);
            cmp_errors++;
         end
         if (access_to_screen !== exp_scr) begin
            $display("ERR %0t access_to_screen exp=%b got=%b", $time, exp_scr,
                     access_to_screen);
            cmp_errors++;
         end
         if (enable_nmi_n !== exp_nmi) begin
            $display("ERR %0t enable_nmi_n exp=%b got=%b", $time, exp_nmi, enable_nmi_n);
            cmp_errors++;
         end
         if (in_boot_mode !== ~m_conf[7]) begin
            $display("ERR %0t in_boot_mode exp=%b got=%b", $time, ~m_conf[7], in_boot_mode);
            cmp_errors++;
         end
         if (in48kmode !== m_7ffd[5]) begin
            $display("ERR %0t in48kmode exp=%b got=%b", $time, m_7ffd[5], in48kmode);
            cmp_errors++;
         end
         if ({timing_mode, issue2_keyboard_enabled, disable_contention} !==
             {m_conf[6], m_conf[4], m_conf[3], m_conf[5]}) begin
            $display("ERR %0t options exp=%b got=%b", $time,
                     {m_conf[6], m_conf[4], m_conf[3], m_conf[5]},
                     {timing_mode, issue2_keyboard_enabled, disable_contention});
            cmp_errors++;
         end
      end
   end

   // --------------------------------------------------
   // bus tasks, one strobe cycle then idle
   // --------------------------------------------------
   task automatic bus_cycle(input cpu_addr_t ca, input byte_t d,
                            input logic mreq, iorq, rd, wr, m1);
      @(negedge clk);
      rnd          = $random(seed);
      ram_dout     = rnd[7:0];                  // fresh data every access
      bootrom_dout = rnd[15:8];
      a      = ca;
      din    = d;
      mreq_n = mreq;
      iorq_n = iorq;
      rd_n   = rd;
      wr_n   = wr;
      m1_n   = m1;
      @(negedge clk);
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
   endtask

   task automatic mem_read(input cpu_addr_t ca);
      bus_cycle(ca, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b1);
   endtask

   task automatic mem_write(input cpu_addr_t ca, input byte_t d);
      bus_cycle(ca, d, 1'b0, 1'b1, 1'b1, 1'b0, 1'b1);
   endtask

   task automatic m1_fetch(input cpu_addr_t ca);
      bus_cycle(ca, 8'h00, 1'b0, 1'b1, 1'b0, 1'b1, 1'b0);
   endtask

   task automatic io_write(input cpu_addr_t port, input byte_t d);
      bus_cycle(port, d, 1'b1, 1'b0, 1'b1, 1'b0, 1'b1);
   endtask

   task automatic reg_access(input byte_t ra, input byte_t d, input logic wr);
      @(negedge clk);
      addr = ra;
      din  = d;
      iow  = wr;
      ior  = !wr;
      @(negedge clk);
      iow = 1'b0;
      ior = 1'b0;
   endtask

   task automatic cpu_reset();
      @(negedge clk);
      rst_n = 1'b0;
      @(negedge clk);
      rst_n = 1'b1;
   endtask

   // a read and a write at a random offset in every quarter
   task automatic sweep_quarters();
      for (j = 0; j < 4; j++) begin
         rnd = $random(seed);
         mem_read({j[1:0], rnd[13:0]});
         mem_write({j[1:0], rnd[29:16]}, rnd[7:0]);
      end
   endtask

   task automatic wait_for_paging(input logic want, input string what);
      int n;
      n = 0;
      while (enable_nmi_n !== want && n < 8) begin
         @(negedge clk);
         n++;
      end
      if (enable_nmi_n !== want) begin
         $display("timeout, divMMC did not %s", what);
         seq_errors++;
      end
   endtask

   task automatic end_test(input string name);
      $display("test %s done, %0d errors", name, cmp_errors + seq_errors - err_mark);
      err_mark = cmp_errors + seq_errors;
      tests++;
   endtask

   // --------------------------------------------------
   // test sequence
   // --------------------------------------------------
   initial begin
      seed = 32'h1db3;
      {cmp_errors, seq_errors, checks, tests, err_mark} = '0;
      chk_en = 1'b0;
      mrst_n = 1'b0;
      rst_n  = 1'b0;
      a      = '0;
      {din, addr, ram_dout, bootrom_dout} = '0;
      {mreq_n, iorq_n, rd_n, wr_n, m1_n} = 5'b11111;
      {ior, iow} = 2'b00;
      repeat (4) @(negedge clk);
      mrst_n = 1'b1;
      rst_n  = 1'b1;
      i = 0;
      while (in_boot_mode !== 1'b1 && i < 10) begin
         @(negedge clk);
         i++;
      end
      if (in_boot_mode !== 1'b1) begin
         $display("timeout, boot mode not seen after reset");
         seq_errors++;
      end
      chk_en = 1'b1;

      // boot rom, master mapper at $C000
      mem_read(16'h0123);
      mem_write(16'h1000, 8'h55);               // boot rom takes no write
      reg_access(`ZXM_MASTERMAPPER, 8'h2B, 1'b1);
      rnd = $random(seed);
      mem_read({2'b11, rnd[13:0]});
      mem_write(16'hC456, 8'hAA);
      reg_access(`ZXM_MASTERCONF, 8'h00, 1'b0);
      reg_access(`ZXM_MASTERMAPPER, 8'h00, 1'b0);
      sweep_quarters();
      end_test("reset_boot");

      // freeze with divmmc on, then only the options move
      reg_access(`ZXM_MASTERCONF, 8'h82, 1'b1);
      reg_access(`ZXM_MASTERCONF, 8'h00, 1'b0);
      reg_access(`ZXM_MASTERCONF, 8'h7D, 1'b1);
      reg_access(`ZXM_MASTERCONF, 8'h00, 1'b0);
      mem_read(16'h0042);
      reg_access(`ZXM_MASTERMAPPER, 8'h3C, 1'b1);
      reg_access(`ZXM_MASTERMAPPER, 8'h00, 1'b0);
      mem_read(16'hC123);
      reg_access(`ZXM_MASTERCONF, 8'h00, 1'b1);
      end_test("freeze");

      // random 128K paging, then lock
      for (i = 0; i < 24; i++) begin
         rnd = $random(seed);
         io_write(16'h7FFD, rnd[7:0] & 8'hDF);
         sweep_quarters();
      end
      io_write(16'h7FFD, 8'h36);                // lock, rom 1, bank 6
      io_write(16'h7FFD, 8'h01);
      io_write(16'h1FFD, 8'h05);
      sweep_quarters();
      cpu_reset();
      end_test("paging128");

      // +3 all-ram arrangements
      for (i = 0; i < 4; i++) begin
         io_write(16'h1FFD, {5'b00000, i[1:0], 1'b1});
         sweep_quarters();
      end
      io_write(16'h1FFD, 8'h00);
      end_test("allram");

      // divmmc automapper
      m1_fetch(16'h0000);
      if (enable_nmi_n !== 1'b0) begin
         $display("divMMC paged inside the M1 cycle at 0000");
         seq_errors++;
      end
      wait_for_paging(1'b1, "page in after the 0000 fetch");
      io_write(16'h00E3, 8'h05);                // ram page 5 at $2000
      mem_read(16'h0100);
      mem_read(16'h2345);
      mem_write(16'h0200, 8'h11);
      mem_write(16'h3000, 8'h22);
      rnd = $random(seed);
      m1_fetch({13'h03FF, rnd[2:0]});
      wait_for_paging(1'b0, "page out after the 1FF8 fetch");
      mem_read(16'h0100);
      m1_fetch({8'h3D, rnd[15:8]});
      if (enable_nmi_n !== 1'b1) begin
         $display("3Dxx fetch did not page divMMC at once");
         seq_errors++;
      end
      mem_read(16'h1234);
      m1_fetch(16'h1FFF);
      wait_for_paging(1'b0, "page out after the 1FFF fetch");
      io_write(16'h00E3, 8'h80);                // conmem
      mem_read(16'h0100);
      mem_write(16'h2100, 8'h33);
      io_write(16'h00E3, 8'h00);
      m1_fetch(16'h0066);
      wait_for_paging(1'b1, "page in at the NMI entry");
      m1_fetch(16'h1FF8);
      wait_for_paging(1'b0, "page out after the 1FF8 fetch");
      io_write(16'h00E3, 8'h43);                // mapram, page 3
      m1_fetch(16'h0038);
      wait_for_paging(1'b1, "page in after the 0038 fetch");
      mem_read(16'h0100);
      mem_write(16'h0100, 8'h44);
      mem_write(16'h2100, 8'h55);
      io_write(16'h00E3, 8'h04);                // mapram stays set
      mem_write(16'h2100, 8'h66);
      cpu_reset();
      mem_read(16'h0100);
      end_test("divmmc");

      // screen contention, normal and all-ram
      for (i = 0; i < 12; i++) begin
         rnd = $random(seed);
         io_write(16'h7FFD, rnd[7:0] & 8'hDF);
         sweep_quarters();
         io_write(16'h1FFD, {5'b00000, rnd[9:8], 1'b1});
         sweep_quarters();
         io_write(16'h1FFD, 8'h00);
      end
      end_test("contention");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, cmp_errors + seq_errors);
      if (cmp_errors + seq_errors == 0)
         $display("sim passed");
      else
         $display("sim failed");
      $finish;
   end

endmodule

//--- zx_memory.f
+incdir+hdl
hdl/zx_mem_pkg.sv
hdl/master_conf.sv
hdl/divmmc_automap.sv
hdl/bank_ports.sv
hdl/addr_translate.sv
hdl/zx_memory.sv
bench/tb_zx_memory.sv

//--- run_sim.sh
#!/bin/sh
# build the memory manager testbench with Verilator and run it
set -e
cd "$(dirname "$0")"

rm -rf obj_dir
verilator --binary --timing --assert -j 0 \
   -f zx_memory.f \
   --top-module tb_zx_memory \
   -o tb_zx_memory

./obj_dir/tb_zx_memory > sim.log 2>&1
cat sim.log

if grep -q "sim failed" sim.log; then
   echo "testbench reported a failure, see sim.log"
   exit 1
fi
exit 0
